// File: logic/mem_bus_cfg.svh
`ifndef MEM_BUS_CFG_SVH
`define MEM_BUS_CFG_SVH

// core side widths
`define MB_ADDR_W 32
`define MB_DATA_W 32

// master data width
`define MB_BUS_W 64

// machine timer words, answered locally
`define MB_MTIME_LO 32'h0200_BFF8
`define MB_MTIME_HI 32'h0200_BFFC

`endif

// File: logic/mem_bus_pkg.sv
`include "mem_bus_cfg.svh"

package mem_bus_pkg;

  // fetch request
  typedef struct packed {
    logic [`MB_ADDR_W-1:0] addr;
  } ifu_req_t;

  // size code: 0 byte, 1 half, 2 word
  typedef struct packed {
    logic [`MB_ADDR_W-1:0] addr;
    logic                  we;
    logic [1:0]            size;
    logic [`MB_DATA_W-1:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic [`MB_DATA_W-1:0] data;
    logic                  err;
  } core_rsp_t;

  // shared by ar and aw
  typedef struct packed {
    logic [`MB_ADDR_W-1:0] addr;
    logic [2:0]            size;
  } ax_t;

  typedef struct packed {
    logic [`MB_BUS_W-1:0]   data;
    logic [`MB_BUS_W/8-1:0] strb;
  } w_t;

  typedef struct packed {
    logic [`MB_BUS_W-1:0] data;
    logic [1:0]           resp;
  } r_t;

  typedef struct packed {
    logic [1:0] resp;
  } b_t;

  typedef enum logic [2:0] {
    IDLE,
    IF_RD,
    LS_RD,
    LS_WR,
    TIMER_RD
  } grant_e;

endpackage

// File: logic/bus_arbiter.sv
`timescale 1ns/10ps
`include "mem_bus_cfg.svh"

module bus_arbiter (
  input  logic                  clk,
  input  logic                  rst,
  // fetch port
  input  mem_bus_pkg::ifu_req_t  ifu_req_i,
  input  logic                   ifu_valid_i,
  output logic                   ifu_ready_o,
  output mem_bus_pkg::core_rsp_t ifu_rsp_o,
  output logic                   ifu_rsp_valid_o,
  // load/store port
  input  mem_bus_pkg::lsu_req_t  lsu_req_i,
  input  logic                   lsu_valid_i,
  output logic                   lsu_ready_o,
  output mem_bus_pkg::core_rsp_t lsu_rsp_o,
  output logic                   lsu_rsp_valid_o,
  // to lane steering and timer
  output mem_bus_pkg::lsu_req_t  cur_req_o,
  input  logic [`MB_DATA_W-1:0]  rd_word_i,
  input  logic [`MB_DATA_W-1:0]  timer_word_i,
  output logic                   timer_sel_o,
  output logic                   timer_rd_o,
  // master handshakes
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  output logic                   w_valid_o,
  input  logic                   w_ready_i,
  input  logic                   r_valid_i,
  input  logic [1:0]             r_resp_i,
  input  logic                   b_valid_i,
  input  logic [1:0]             b_resp_i
);

  mem_bus_pkg::grant_e    state;
  mem_bus_pkg::lsu_req_t  cur_q;
  mem_bus_pkg::core_rsp_t rsp_q;

  logic ar_valid_q;
  logic aw_valid_q;
  logic w_valid_q;
  logic ifu_rsp_valid_q;
  logic lsu_rsp_valid_q;

  logic lsu_accept;
  logic ifu_accept;
  logic lsu_is_timer;

  // lsu wins whenever both are waiting
  assign lsu_ready_o = (state == mem_bus_pkg::IDLE);
  assign ifu_ready_o = (state == mem_bus_pkg::IDLE) && !lsu_valid_i;

  assign lsu_accept = lsu_valid_i && lsu_ready_o;
  assign ifu_accept = ifu_valid_i && ifu_ready_o;

  assign lsu_is_timer = !lsu_req_i.we &&
                        ((lsu_req_i.addr == `MB_MTIME_LO) ||
                         (lsu_req_i.addr == `MB_MTIME_HI));

  // timer samples the counter in the accept cycle
  assign timer_rd_o  = lsu_accept && lsu_is_timer;
  assign timer_sel_o = (lsu_req_i.addr == `MB_MTIME_HI);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state           <= mem_bus_pkg::IDLE;
      ar_valid_q      <= 1'b0;
      aw_valid_q      <= 1'b0;
      w_valid_q       <= 1'b0;
      ifu_rsp_valid_q <= 1'b0;
      lsu_rsp_valid_q <= 1'b0;
    end
    else
    begin
      ifu_rsp_valid_q <= 1'b0;
      lsu_rsp_valid_q <= 1'b0;
      case (state)
        mem_bus_pkg::IDLE:
        begin
          if (lsu_accept)
          begin
            if (lsu_is_timer)
            begin
              state <= mem_bus_pkg::TIMER_RD;
            end
            else if (lsu_req_i.we)
            begin
              state      <= mem_bus_pkg::LS_WR;
              aw_valid_q <= 1'b1;
              w_valid_q  <= 1'b1;
            end
            else
            begin
              state      <= mem_bus_pkg::LS_RD;
              ar_valid_q <= 1'b1;
            end
          end
          else if (ifu_accept)
          begin
            state      <= mem_bus_pkg::IF_RD;
            ar_valid_q <= 1'b1;
          end
        end
        mem_bus_pkg::IF_RD, mem_bus_pkg::LS_RD:
        begin
          if (ar_ready_i)
          begin
            ar_valid_q <= 1'b0;
          end
          if (r_valid_i)
          begin
            state           <= mem_bus_pkg::IDLE;
            ifu_rsp_valid_q <= (state == mem_bus_pkg::IF_RD);
            lsu_rsp_valid_q <= (state == mem_bus_pkg::LS_RD);
          end
        end
        mem_bus_pkg::LS_WR:
        begin
          // aw and w may complete in either order
          if (aw_ready_i)
          begin
            aw_valid_q <= 1'b0;
          end
          if (w_ready_i)
          begin
            w_valid_q <= 1'b0;
          end
          if (b_valid_i)
          begin
            state           <= mem_bus_pkg::IDLE;
            lsu_rsp_valid_q <= 1'b1;
          end
        end
        mem_bus_pkg::TIMER_RD:
        begin
          state           <= mem_bus_pkg::IDLE;
          lsu_rsp_valid_q <= 1'b1;
        end
        default:
        begin
          state <= mem_bus_pkg::IDLE;
        end
      endcase
    end
  end

  // captured request and response payload
  always_ff @(posedge clk)
  begin
    if (lsu_accept)
    begin
      cur_q <= lsu_req_i;
    end
    else if (ifu_accept)
    begin
      cur_q <= '{addr: ifu_req_i.addr, we: 1'b0, size: 2'd2, wdata: '0};
    end

    case (state)
      mem_bus_pkg::IF_RD, mem_bus_pkg::LS_RD:
      begin
        rsp_q.data <= rd_word_i;
        rsp_q.err  <= |r_resp_i;
      end
      mem_bus_pkg::LS_WR:
      begin
        rsp_q.data <= '0;
        rsp_q.err  <= |b_resp_i;
      end
      mem_bus_pkg::TIMER_RD:
      begin
        rsp_q.data <= timer_word_i;
        rsp_q.err  <= 1'b0;
      end
      default:
      begin
        rsp_q <= rsp_q;
      end
    endcase
  end

  assign cur_req_o       = cur_q;
  assign ar_valid_o      = ar_valid_q;
  assign aw_valid_o      = aw_valid_q;
  assign w_valid_o       = w_valid_q;
  assign ifu_rsp_o       = rsp_q;
  assign lsu_rsp_o       = rsp_q;
  assign ifu_rsp_valid_o = ifu_rsp_valid_q;
  assign lsu_rsp_valid_o = lsu_rsp_valid_q;

endmodule

// File: logic/lane_steer.sv
`timescale 1ns/10ps
`include "mem_bus_cfg.svh"

module lane_steer (
  input  mem_bus_pkg::lsu_req_t cur_req_i,
  output mem_bus_pkg::ax_t      ar_o,
  output mem_bus_pkg::ax_t      aw_o,
  output mem_bus_pkg::w_t       w_o,
  input  mem_bus_pkg::r_t       r_i,
  output logic [`MB_DATA_W-1:0] rd_word_o
);

  localparam int LANES = `MB_DATA_W / 8;

  mem_bus_pkg::ax_t      ax;
  logic [LANES-1:0]      size_mask;
  logic [LANES-1:0]      lane_mask;
  logic [`MB_DATA_W-1:0] wdata_sh;

  // axi size follows the size code directly
  assign ax.addr = cur_req_i.addr;
  assign ax.size = {1'b0, cur_req_i.size};

  assign ar_o = ax;
  assign aw_o = ax;

  always_comb
  begin
    case (cur_req_i.size)
      2'd0:    size_mask = 4'b0001;
      2'd1:    size_mask = 4'b0011;
      default: size_mask = 4'b1111;
    endcase
  end

  assign lane_mask = size_mask << cur_req_i.addr[1:0];

  // upper half of the strobe for the odd word
  assign w_o.strb = cur_req_i.addr[2] ? {lane_mask, {LANES{1'b0}}}
                                      : {{LANES{1'b0}}, lane_mask};

  assign wdata_sh = cur_req_i.wdata << {cur_req_i.addr[1:0], 3'b000};

  // same word in both halves
  assign w_o.data = {wdata_sh, wdata_sh};

  // read half picked by addr bit 2, no shift
  assign rd_word_o = cur_req_i.addr[2] ? r_i.data[`MB_BUS_W-1:`MB_DATA_W]
                                       : r_i.data[`MB_DATA_W-1:0];

endmodule

// File: logic/mtime_timer.sv
`timescale 1ns/10ps
`include "mem_bus_cfg.svh"

module mtime_timer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rd_i,
  input  logic                  hi_sel_i,
  output logic [`MB_DATA_W-1:0] word_o
);

  logic [63:0] mtime;

  // free-running cycle count
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime <= '0;
    end
    else
    begin
      mtime <= mtime + 64'd1;
    end
  end

  // holds the value seen in the accept cycle
  always_ff @(posedge clk)
  begin
    if (rd_i)
    begin
      word_o <= hi_sel_i ? mtime[63:32] : mtime[31:0];
    end
  end

endmodule

// File: logic/mem_bus_top.sv
`timescale 1ns/10ps
`include "mem_bus_cfg.svh"

module mem_bus_top (
  input  logic                   clk,
  input  logic                   rst,
  // fetch port
  input  mem_bus_pkg::ifu_req_t  ifu_req_i,
  input  logic                   ifu_valid_i,
  output logic                   ifu_ready_o,
  output mem_bus_pkg::core_rsp_t ifu_rsp_o,
  output logic                   ifu_rsp_valid_o,
  // load/store port
  input  mem_bus_pkg::lsu_req_t  lsu_req_i,
  input  logic                   lsu_valid_i,
  output logic                   lsu_ready_o,
  output mem_bus_pkg::core_rsp_t lsu_rsp_o,
  output logic                   lsu_rsp_valid_o,
  // master port
  output mem_bus_pkg::ax_t       ar_o,
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output mem_bus_pkg::ax_t       aw_o,
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  output mem_bus_pkg::w_t        w_o,
  output logic                   w_valid_o,
  input  logic                   w_ready_i,
  input  mem_bus_pkg::r_t        r_i,
  input  logic                   r_valid_i,
  output logic                   r_ready_o,
  input  mem_bus_pkg::b_t        b_i,
  input  logic                   b_valid_i,
  output logic                   b_ready_o
);

  mem_bus_pkg::lsu_req_t cur_req;
  logic [`MB_DATA_W-1:0] rd_word;
  logic [`MB_DATA_W-1:0] timer_word;
  logic                  timer_sel;
  logic                  timer_rd;

  // responses are never stalled
  assign r_ready_o = 1'b1;
  assign b_ready_o = 1'b1;

  bus_arbiter u_arbiter (
    .clk             (clk),
    .rst             (rst),
    .ifu_req_i       (ifu_req_i),
    .ifu_valid_i     (ifu_valid_i),
    .ifu_ready_o     (ifu_ready_o),
    .ifu_rsp_o       (ifu_rsp_o),
    .ifu_rsp_valid_o (ifu_rsp_valid_o),
    .lsu_req_i       (lsu_req_i),
    .lsu_valid_i     (lsu_valid_i),
    .lsu_ready_o     (lsu_ready_o),
    .lsu_rsp_o       (lsu_rsp_o),
    .lsu_rsp_valid_o (lsu_rsp_valid_o),
    .cur_req_o       (cur_req),
    .rd_word_i       (rd_word),
    .timer_word_i    (timer_word),
    .timer_sel_o     (timer_sel),
    .timer_rd_o      (timer_rd),
    .ar_valid_o      (ar_valid_o),
    .ar_ready_i      (ar_ready_i),
    .aw_valid_o      (aw_valid_o),
    .aw_ready_i      (aw_ready_i),
    .w_valid_o       (w_valid_o),
    .w_ready_i       (w_ready_i),
    .r_valid_i       (r_valid_i),
    .r_resp_i        (r_i.resp),
    .b_valid_i       (b_valid_i),
    .b_resp_i        (b_i.resp)
  );

  lane_steer u_lane_steer (
    .cur_req_i (cur_req),
    .ar_o      (ar_o),
    .aw_o      (aw_o),
    .w_o       (w_o),
    .r_i       (r_i),
    .rd_word_o (rd_word)
  );

  mtime_timer u_mtime (
    .clk      (clk),
    .rst      (rst),
    .rd_i     (timer_rd),
    .hi_sel_i (timer_sel),
    .word_o   (timer_word)
  );

endmodule

// File: tests/axi_mem_model.sv
`timescale 1ns/10ps

module axi_mem_model #(
  parameter logic [31:0] SEED = 32'h1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  mem_bus_pkg::ax_t      ar_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  input  mem_bus_pkg::ax_t      aw_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  mem_bus_pkg::w_t       w_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  output mem_bus_pkg::r_t       r_o,
  output logic                  r_valid_o,
  output mem_bus_pkg::b_t       b_o,
  output logic                  b_valid_o,
  output int                    err_cnt_o
);

  logic [7:0] mem [logic [31:0]];
  int seed;
  int ar_cnt, aw_cnt, w_cnt, r_cnt, b_cnt;
  logic ar_seen, aw_seen, w_seen;
  logic r_pend, b_pend, aw_done, w_done;
  mem_bus_pkg::ax_t ar_q, aw_q, wr_ax;
  mem_bus_pkg::w_t  w_q, wr_beat;
  logic [31:0] rd_addr;

  // initial contents, every address bit matters
  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  function int rand_delay();
    return int'($unsigned($random(seed)) % 5);
  endfunction

  function automatic logic [63:0] read_beat(input logic [31:0] a);
    logic [63:0] d;
    logic [31:0] base;
    base = {a[31:3], 3'b000};
    for (int i = 0; i < 8; i++)
    begin
      d[8*i +: 8] = mem.exists(base + i) ? mem[base + i] : fill_byte(base + i);
    end
    return d;
  endfunction

  task automatic hold_check(input logic ok, input string what);
    if (!ok)
    begin
      err_cnt_o++;
      $display("FAILED %0t: %s", $time, what);
    end
  endtask

  // ready comes up 0 to 4 cycles after valid
  task automatic step_ready(input logic valid, input logic seen, inout logic ready,
                            inout int cnt);
    if (valid && !seen)
    begin
      cnt = rand_delay();
    end
    if (valid && !ready)
    begin
      if (cnt == 0)
        ready = 1'b1;
      else
        cnt--;
    end
  endtask

  initial
  begin
    seed = SEED;
    err_cnt_o = 0;
    {ar_ready_o, aw_ready_o, w_ready_o, r_valid_o, b_valid_o} = '0;
    {ar_seen, aw_seen, w_seen, r_pend, b_pend, aw_done, w_done} = '0;
    r_o = '0;
    b_o = '0;
    forever
    begin
      @(posedge clk);
      #1;
      if (rst)
      begin
        {ar_ready_o, aw_ready_o, w_ready_o, r_valid_o, b_valid_o} = '0;
        {ar_seen, aw_seen, w_seen, r_pend, b_pend, aw_done, w_done} = '0;
        continue;
      end
      // handshakes at the edge just passed
      if (ar_seen && ar_ready_o)
      begin
        rd_addr = ar_q.addr;
        r_pend = 1'b1;
        r_cnt = rand_delay();
        ar_ready_o = 1'b0;
      end
      else if (ar_seen)
        hold_check(ar_valid_i && ar_i == ar_q, "ar moved while stalled");
      if (aw_seen && aw_ready_o)
      begin
        wr_ax = aw_q;
        aw_done = 1'b1;
        aw_ready_o = 1'b0;
      end
      else if (aw_seen)
        hold_check(aw_valid_i && aw_i == aw_q, "aw moved while stalled");
      if (w_seen && w_ready_o)
      begin
        wr_beat = w_q;
        w_done = 1'b1;
        w_ready_o = 1'b0;
      end
      else if (w_seen)
        hold_check(w_valid_i && w_i == w_q, "w moved while stalled");

      r_valid_o = 1'b0;
      b_valid_o = 1'b0;
      if (r_pend)
      begin
        if (r_cnt == 0)
        begin
          r_pend = 1'b0;
          r_valid_o = 1'b1;
          if (rd_addr >= 32'h3000_0000)
            r_o = '{data: '0, resp: 2'd2};
          else
            r_o = '{data: read_beat(rd_addr), resp: 2'd0};
        end
        else
          r_cnt--;
      end
      if (aw_done && w_done && !b_pend)
      begin
        aw_done = 1'b0;
        w_done = 1'b0;
        b_pend = 1'b1;
        b_cnt = rand_delay();
        b_o.resp = (wr_ax.addr >= 32'h3000_0000) ? 2'd2 : 2'd0;
        if (b_o.resp == 2'd0)
        begin
          for (int i = 0; i < 8; i++)
          begin
            if (wr_beat.strb[i])
              mem[{wr_ax.addr[31:3], 3'b000} + i] = wr_beat.data[8*i +: 8];
          end
        end
      end
      if (b_pend)
      begin
        if (b_cnt == 0)
        begin
          b_pend = 1'b0;
          b_valid_o = 1'b1;
        end
        else
          b_cnt--;
      end

      step_ready(ar_valid_i, ar_seen, ar_ready_o, ar_cnt);
      step_ready(aw_valid_i, aw_seen, aw_ready_o, aw_cnt);
      step_ready(w_valid_i, w_seen, w_ready_o, w_cnt);
      ar_seen = ar_valid_i;
      aw_seen = aw_valid_i;
      w_seen = w_valid_i;
      ar_q = ar_i;
      aw_q = aw_i;
      w_q = w_i;
    end
  end

endmodule

// File: tests/tb_mem_bus.sv
`timescale 1ns/10ps
`include "mem_bus_cfg.svh"

module tb_mem_bus;

  localparam int TMO = 200;

  typedef struct packed {
    logic [31:0] data;
    logic        err;
    logic        timer;
    logic [63:0] acc;
  } exp_t;

  logic clk, rst;
  mem_bus_pkg::ifu_req_t  ifu_req;
  mem_bus_pkg::lsu_req_t  lsu_req;
  mem_bus_pkg::core_rsp_t ifu_rsp, lsu_rsp;
  logic ifu_valid, ifu_ready, ifu_rsp_valid;
  logic lsu_valid, lsu_ready, lsu_rsp_valid;
  mem_bus_pkg::ax_t ar, aw;
  mem_bus_pkg::w_t  w;
  mem_bus_pkg::r_t  r;
  mem_bus_pkg::b_t  b;
  logic ar_valid, ar_ready, aw_valid, aw_ready, w_valid, w_ready;
  logic r_valid, r_ready, b_valid, b_ready;
  int model_errs;

  int seed = 32'h9cc3_1651;
  int checks = 0;
  int errors = 0;
  logic [63:0] cyc;
  logic timer_pend = 1'b0;
  logic [7:0] shadow [logic [31:0]];
  exp_t ifu_q[$];
  exp_t lsu_q[$];
  mem_bus_pkg::ax_t exp_ax;
  mem_bus_pkg::w_t  exp_w;

  mem_bus_top u_dut (
    .clk (clk), .rst (rst),
    .ifu_req_i (ifu_req), .ifu_valid_i (ifu_valid), .ifu_ready_o (ifu_ready),
    .ifu_rsp_o (ifu_rsp), .ifu_rsp_valid_o (ifu_rsp_valid),
    .lsu_req_i (lsu_req), .lsu_valid_i (lsu_valid), .lsu_ready_o (lsu_ready),
    .lsu_rsp_o (lsu_rsp), .lsu_rsp_valid_o (lsu_rsp_valid),
    .ar_o (ar), .ar_valid_o (ar_valid), .ar_ready_i (ar_ready),
    .aw_o (aw), .aw_valid_o (aw_valid), .aw_ready_i (aw_ready),
    .w_o (w), .w_valid_o (w_valid), .w_ready_i (w_ready),
    .r_i (r), .r_valid_i (r_valid), .r_ready_o (r_ready),
    .b_i (b), .b_valid_i (b_valid), .b_ready_o (b_ready)
  );

  axi_mem_model #(.SEED (32'h9cc3_1651)) u_mem (
    .clk (clk), .rst (rst),
    .ar_i (ar), .ar_valid_i (ar_valid), .ar_ready_o (ar_ready),
    .aw_i (aw), .aw_valid_i (aw_valid), .aw_ready_o (aw_ready),
    .w_i (w), .w_valid_i (w_valid), .w_ready_o (w_ready),
    .r_o (r), .r_valid_o (r_valid), .b_o (b), .b_valid_o (b_valid),
    .err_cnt_o (model_errs)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // mtime equivalent that reads zero in the first cycle out of reset
  always @(posedge clk)
  begin
    if (rst)
      cyc <= '0;
    else
      cyc <= cyc + 64'd1;
  end

  task automatic check_val(input logic [63:0] got, input logic [63:0] exp,
                           input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("checks %0d errors %0d model errors %0d", checks, errors, model_errs);
    $display(">>> FAIL");
    $finish;
  endtask

  function automatic logic [7:0] shadow_byte(input logic [31:0] a);
    if (shadow.exists(a))
      return shadow[a];
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  function automatic logic [3:0] size_mask(input logic [1:0] size);
    return (size == 2'd0) ? 4'b0001 : (size == 2'd1) ? 4'b0011 : 4'b1111;
  endfunction

  // w beat a store should put on the 64-bit bus
  function automatic mem_bus_pkg::w_t store_beat(input mem_bus_pkg::lsu_req_t req);
    mem_bus_pkg::w_t beat;
    logic [3:0]      m;
    logic [31:0]     wsh;
    m = size_mask(req.size) << req.addr[1:0];
    wsh = req.wdata << (8 * req.addr[1:0]);
    beat.data = {wsh, wsh};
    beat.strb = req.addr[2] ? {m, 4'b0000} : {4'b0000, m};
    return beat;
  endfunction

  // expected response for a request accepted at cycle now
  function automatic exp_t ref_rsp(input mem_bus_pkg::lsu_req_t req, input logic [63:0] now);
    exp_t e;
    logic [31:0] base;
    e = '0;
    e.acc = now;
    base = {req.addr[31:2], 2'b00};
    if (!req.we && (req.addr == `MB_MTIME_LO || req.addr == `MB_MTIME_HI))
    begin
      e.timer = 1'b1;
      e.data = (req.addr == `MB_MTIME_HI) ? now[63:32] : now[31:0];
    end
    else if (req.addr >= 32'h3000_0000)
      e.err = 1'b1;
    else if (!req.we)
    begin
      for (int i = 0; i < 4; i++)
        e.data[8*i +: 8] = shadow_byte(base + i);
    end
    return e;
  endfunction

  task automatic apply_store(input mem_bus_pkg::lsu_req_t req);
    logic [3:0]  m;
    logic [31:0] wsh;
    m = size_mask(req.size) << req.addr[1:0];
    wsh = req.wdata << (8 * req.addr[1:0]);
    for (int j = 0; j < 4; j++)
    begin
      if (m[j])
        shadow[{req.addr[31:2], 2'b00} + j] = wsh[8*j +: 8];
    end
  endtask

  // compare and bookkeeping on the falling edge
  always @(negedge clk)
  begin
    exp_t e;
    mem_bus_pkg::lsu_req_t fetch;
    if (!rst)
    begin
      if (lsu_rsp_valid)
      begin
        if (lsu_q.size() == 0)
          check_val(1, 0, "lsu response without request");
        else
        begin
          e = lsu_q.pop_front();
          check_val(lsu_rsp.data, e.data, "lsu data");
          check_val(lsu_rsp.err, e.err, "lsu error flag");
          if (e.timer)
          begin
            check_val(cyc, e.acc + 64'd2, "timer latency");
            timer_pend = 1'b0;
          end
        end
      end
      if (ifu_rsp_valid)
      begin
        if (ifu_q.size() == 0)
          check_val(1, 0, "ifu response without request");
        else
        begin
          e = ifu_q.pop_front();
          check_val(ifu_rsp.data, e.data, "ifu data");
          check_val(ifu_rsp.err, e.err, "ifu error flag");
        end
      end
      check_val({r_ready, b_ready}, 2'b11, "r or b ready low");
      if (ar_valid)
        check_val(ar, exp_ax, "ar fields");
      if (aw_valid)
        check_val(aw, exp_ax, "aw fields");
      if (w_valid)
      begin
        check_val(w.data, exp_w.data, "w data");
        check_val(w.strb, exp_w.strb, "w strobe");
      end
      if (timer_pend)
        check_val(ar_valid, 0, "ar issued for timer read");
      if (lsu_valid)
        check_val(ifu_ready, 0, "ifu ready while lsu waits");
      if (lsu_valid && lsu_ready)
      begin
        e = ref_rsp(lsu_req, cyc);
        timer_pend = e.timer;
        lsu_q.push_back(e);
        exp_ax = '{addr: lsu_req.addr, size: {1'b0, lsu_req.size}};
        exp_w = store_beat(lsu_req);
        if (lsu_req.we && !e.err)
          apply_store(lsu_req);
      end
      if (ifu_valid && ifu_ready)
      begin
        fetch = '{addr: ifu_req.addr, we: 1'b0, size: 2'd2, wdata: '0};
        exp_ax = '{addr: ifu_req.addr, size: 3'd2};
        ifu_q.push_back(ref_rsp(fetch, cyc));
      end
    end
  end

  task automatic idle_gap();
    repeat ($unsigned($random(seed)) % 3)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_lsu(input int n);
    mem_bus_pkg::lsu_req_t req;
    int kind;
    int t;
    for (int k = 0; k < n; k++)
    begin
      kind = int'($unsigned($random(seed)) % 16);
      req.we = $random(seed) & 1;
      req.size = 2'($unsigned($random(seed)) % 3);
      req.wdata = $random(seed);
      req.addr = 32'h1000_0000 + 32'(($unsigned($random(seed)) % 16) * 4);
      if (req.size == 2'd0)
        req.addr[1:0] = 2'($random(seed));
      else if (req.size == 2'd1)
        req.addr[1:0] = 2'($unsigned($random(seed)) % 3);
      if (kind < 2)
      begin
        req.we = 1'b0;
        req.addr = (kind == 0) ? `MB_MTIME_LO : `MB_MTIME_HI;
      end
      else if (kind == 2)
        req.addr = 32'h3000_0000 + req.addr[5:0];
      lsu_req = req;
      lsu_valid = 1'b1;
      t = 0;
      do
      begin
        @(negedge clk);
        t++;
        if (t > TMO)
          abort_run("lsu request never accepted");
      end
      while (!lsu_ready);
      @(posedge clk);
      #1;
      lsu_valid = 1'b0;
      t = 0;
      do
      begin
        @(negedge clk);
        t++;
        if (t > TMO)
          abort_run("no lsu response");
      end
      while (!lsu_rsp_valid);
      @(posedge clk);
      #1;
      idle_gap();
    end
  endtask

  task automatic run_ifu(input int n);
    int t;
    for (int k = 0; k < n; k++)
    begin
      ifu_req.addr = 32'h1000_0000 + 32'(($unsigned($random(seed)) % 16) * 4);
      if ($unsigned($random(seed)) % 16 == 0)
        ifu_req.addr = 32'h3000_0040;
      ifu_valid = 1'b1;
      t = 0;
      do
      begin
        @(negedge clk);
        t++;
        if (t > TMO)
          abort_run("fetch never accepted");
      end
      while (!ifu_ready);
      @(posedge clk);
      #1;
      ifu_valid = 1'b0;
      t = 0;
      do
      begin
        @(negedge clk);
        t++;
        if (t > TMO)
          abort_run("no fetch response");
      end
      while (!ifu_rsp_valid);
      @(posedge clk);
      #1;
      idle_gap();
    end
  endtask

  initial
  begin
    rst = 1'b1;
    ifu_req = '0;
    ifu_valid = 1'b0;
    lsu_req = '0;
    lsu_valid = 1'b0;
    exp_ax = '0;
    exp_w = '0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    // idle straight out of reset
    check_val({lsu_ready, ifu_ready}, 2'b11, "request ready after reset");
    check_val({ar_valid, aw_valid, w_valid}, 3'b000, "master valid after reset");
    check_val({ifu_rsp_valid, lsu_rsp_valid}, 2'b00, "response valid after reset");
    fork
      run_lsu(400);
      run_ifu(300);
    join
    repeat (20) @(posedge clk);
    check_val(lsu_q.size(), 0, "lsu responses missing");
    check_val(ifu_q.size(), 0, "ifu responses missing");
    $display("checks %0d errors %0d model errors %0d", checks, errors, model_errs);
    if (errors == 0 && model_errs == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// File: sim.f
+incdir+logic
logic/mem_bus_pkg.sv
logic/bus_arbiter.sv
logic/lane_steer.sv
logic/mtime_timer.sv
logic/mem_bus_top.sv
tests/axi_mem_model.sv
tests/tb_mem_bus.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_bus
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= >>> PASS

BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard logic/*.sv logic/*.svh tests/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
